// ==== design/board_io_pkg.sv ====
// Board-side definitions for the player input front end
// Pad pin vector, keyboard row/column types, scan FSM states and defaults

`default_nettype none

package board_io_pkg;

	//----------------------------------------------------------------------
	// Physical pin types
	//----------------------------------------------------------------------

	// Active-low pad reading: fire B, fire A, up, down, left, right
	typedef logic [5:0] pad_pins_t;

	// Active-low membrane row drive and column reading
	typedef logic [7:0] key_row_t;
	typedef logic [6:0] key_col_t;

	typedef logic [2:0] row_idx_t;
	typedef logic [2:0] col_idx_t;

	// Bit positions inside pad_pins_t
	localparam int PAD_RIGHT  = 0;
	localparam int PAD_LEFT   = 1;
	localparam int PAD_DOWN   = 2;
	localparam int PAD_UP     = 3;
	localparam int PAD_FIRE_A = 4;
	localparam int PAD_FIRE_B = 5;

	//----------------------------------------------------------------------
	// Scan timing
	//----------------------------------------------------------------------

	typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

	// Clock cycles each keyboard row stays driven
	localparam int SCAN_DIV_DEFAULT = 16;
	localparam int DEBOUNCE_BITS_DEFAULT = 4;

endpackage

`default_nettype wire

// ==== design/game_io_pkg.sv ====
// Game-side definitions for the player input front end
// Control and settings structs, decoded key vector and membrane key map

`default_nettype none

package game_io_pkg;

	// Active-high controls handed to the game core
	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic fire_a;
		logic fire_b;
		logic up;
		logic down;
		logic left;
		logic right;
	} game_ctrl_t;

	// Toggled settings: button pattern overlay and scan doubler
	typedef struct packed {
		logic patterns;
		logic scandoubler;
	} settings_t;

	//----------------------------------------------------------------------
	// Decoded membrane functions
	//----------------------------------------------------------------------

	localparam int KEY_FN_BITS = 11;

	// Bits 8..0 line up with game_ctrl_t, settings keys on top
	typedef logic [KEY_FN_BITS-1:0] key_fn_t;

	localparam int KEY_RIGHT    = 0;
	localparam int KEY_LEFT     = 1;
	localparam int KEY_DOWN     = 2;
	localparam int KEY_UP       = 3;
	localparam int KEY_FIRE_B   = 4;
	localparam int KEY_FIRE_A   = 5;
	localparam int KEY_START2   = 6;
	localparam int KEY_START1   = 7;
	localparam int KEY_COIN     = 8;
	localparam int KEY_PATTERNS = 9;
	localparam int KEY_SCANDB   = 10;

	typedef struct packed {
		board_io_pkg::row_idx_t row;
		board_io_pkg::col_idx_t col;
	} key_pos_t;

	// Row and column of each key_fn_t bit, cursor keys 5 to 8 for directions
	localparam key_pos_t KEY_MAP [0:KEY_FN_BITS-1] = '{
		'{row: 3'd4, col: 3'd2},
		'{row: 3'd3, col: 3'd4},
		'{row: 3'd4, col: 3'd4},
		'{row: 3'd4, col: 3'd3},
		'{row: 3'd7, col: 3'd0},
		'{row: 3'd4, col: 3'd0},
		'{row: 3'd3, col: 3'd1},
		'{row: 3'd3, col: 3'd0},
		'{row: 3'd3, col: 3'd2},
		'{row: 3'd5, col: 3'd0},
		'{row: 3'd0, col: 3'd5}
	};

endpackage

`default_nettype wire

// ==== design/scan_sequencer.sv ====
// Scan sequencer for the shared pad connector and the membrane keyboard
// Pad select toggle, row index counter and column sample strobe

`timescale 1ns/100ps
`default_nettype none

module scan_sequencer #(
	parameter int SCAN_DIV = 16
) (
	input  wire                    btn_patrons_s,
	input  wire                    reset_i,
	output logic                   joysel_o,
	output board_io_pkg::row_idx_t row_idx_o,
	output logic                   col_sample_o
);

	import board_io_pkg::*;

	localparam int DW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam logic [DW-1:0] DWELL_LAST = DW'(SCAN_DIV - 1);

	scan_state_t   state;
	logic [DW-1:0] dwell;

	//----------------------------------------------------------------------
	// Sequencer FSM
	//----------------------------------------------------------------------

	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			state        <= SCAN_IDLE;
			joysel_o     <= 1'b0;
			dwell        <= '0;
			row_idx_o    <= '0;
			col_sample_o <= 1'b0;
		end
		else
		begin
			case (state)
				SCAN_IDLE:
				begin
					// Start on row 0 right after reset
					state        <= SCAN_RUN;
					dwell        <= '0;
					row_idx_o    <= '0;
					col_sample_o <= 1'b0;
				end
				SCAN_RUN:
				begin
					joysel_o <= ~joysel_o;
					// Strobe lands on the last cycle of the dwell
					col_sample_o <= (dwell == DWELL_LAST - 1'b1);
					if (dwell == DWELL_LAST)
					begin
						dwell     <= '0;
						row_idx_o <= row_idx_o + 1'b1;
					end
					else
					begin
						dwell <= dwell + 1'b1;
					end
				end
				default:
				begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

	a_no_sample_idle: assert property (@(posedge btn_patrons_s) disable iff (reset_i)
		(state == SCAN_IDLE) |-> !col_sample_o)
		else $error("column sample strobe while sequencer idle");

endmodule

`default_nettype wire

// ==== design/pad_sampler.sv ====
// Pad sampler for two joypads sharing one connector
// Inverts the active-low pins and splits captures by select phase

`timescale 1ns/100ps
`default_nettype none

module pad_sampler (
	input  wire                     btn_patrons_s,
	input  wire                     reset_i,
	input  wire                     joysel_i,
	input  wire board_io_pkg::pad_pins_t joy_pins_i,
	output board_io_pkg::pad_pins_t pad_a_o,
	output board_io_pkg::pad_pins_t pad_b_o
);

	import board_io_pkg::*;

	pad_pins_t pins_active;

	// Pins idle high, pressed buttons read low
	assign pins_active = ~joy_pins_i;

	//----------------------------------------------------------------------
	// Per-pad capture
	//----------------------------------------------------------------------

	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			pad_a_o <= '0;
			pad_b_o <= '0;
		end
		else
		begin
			// Select low means the connector shows pad A
			if (joysel_i)
			begin
				pad_b_o <= pins_active;
			end
			else
			begin
				pad_a_o <= pins_active;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/membrane_decoder.sv ====
// Membrane keyboard decoder
// Row drive from the scan index and per-row column sampling into key_fn_t

`timescale 1ns/100ps
`default_nettype none

module membrane_decoder (
	input  wire                     btn_patrons_s,
	input  wire                     reset_i,
	input  wire board_io_pkg::row_idx_t row_idx_i,
	input  wire                     col_sample_i,
	input  wire board_io_pkg::key_col_t keyb_col_i,
	output board_io_pkg::key_row_t  keyb_row_o,
	output game_io_pkg::key_fn_t    key_fn_o
);

	import board_io_pkg::*;
	import game_io_pkg::*;

	//----------------------------------------------------------------------
	// Row drive
	//----------------------------------------------------------------------

	// Registered, so rows stay high until the first cycle out of reset,
	// which is the cycle the sequencer starts running
	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			keyb_row_o <= '1;
		end
		else
		begin
			keyb_row_o <= ~(key_row_t'(1) << row_idx_i);
		end
	end

	//----------------------------------------------------------------------
	// Column sampling
	//----------------------------------------------------------------------

	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			key_fn_o <= '0;
		end
		else if (col_sample_i)
		begin
			// Only keys on the current row are refreshed
			for (int i = 0; i < KEY_FN_BITS; i++)
			begin
				if (KEY_MAP[i].row == row_idx_i)
				begin
					key_fn_o[i] <= ~keyb_col_i[KEY_MAP[i].col];
				end
			end
		end
	end

	a_one_row_low: assert property (@(posedge btn_patrons_s) disable iff (reset_i)
		$onehot0(~keyb_row_o))
		else $error("more than one keyboard row driven low");

endmodule

`default_nettype wire

// ==== design/debounce_bank.sv ====
// Debouncer for the two settings keys
// One saturating stability counter per bit

`timescale 1ns/100ps
`default_nettype none

module debounce_bank #(
	parameter int DEBOUNCE_BITS = 4
) (
	input  wire        btn_patrons_s,
	input  wire        reset_i,
	input  wire  [1:0] raw_i,
	output logic [1:0] clean_o
);

	logic [DEBOUNCE_BITS-1:0] cnt [2];

	//----------------------------------------------------------------------
	// Stability counters
	//----------------------------------------------------------------------

	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			clean_o <= '0;
			for (int i = 0; i < 2; i++)
			begin
				cnt[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (raw_i[i] == clean_o[i])
				begin
					// Input back at the clean level, start over
					cnt[i] <= '0;
				end
				else if (cnt[i] == '1)
				begin
					clean_o[i] <= raw_i[i];
					cnt[i]     <= '0;
				end
				else
				begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/control_merge.sv ====
// Control merge for pads and membrane keys
// Registered game controls and the two toggled settings

`timescale 1ns/100ps
`default_nettype none

module control_merge (
	input  wire                      btn_patrons_s,
	input  wire                      reset_i,
	input  wire board_io_pkg::pad_pins_t pad_a_i,
	input  wire board_io_pkg::pad_pins_t pad_b_i,
	input  wire game_io_pkg::key_fn_t    key_fn_i,
	input  wire [1:0]                buttons_clean_i,
	output game_io_pkg::game_ctrl_t  game_ctrl_o,
	output game_io_pkg::settings_t   settings_o
);

	import board_io_pkg::*;
	import game_io_pkg::*;

	// bit 0 patterns, bit 1 scandoubler
	logic [1:0] clean_q;
	logic [1:0] rise;

	assign rise = buttons_clean_i & ~clean_q;

	//----------------------------------------------------------------------
	// Game controls
	//----------------------------------------------------------------------

	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			game_ctrl_o <= '0;
		end
		else
		begin
			// Coin and starts only exist on the keyboard
			game_ctrl_o.coin   <= key_fn_i[KEY_COIN];
			game_ctrl_o.start1 <= key_fn_i[KEY_START1];
			game_ctrl_o.start2 <= key_fn_i[KEY_START2];
			game_ctrl_o.fire_a <= pad_a_i[PAD_FIRE_A] | pad_b_i[PAD_FIRE_A] | key_fn_i[KEY_FIRE_A];
			game_ctrl_o.fire_b <= pad_a_i[PAD_FIRE_B] | pad_b_i[PAD_FIRE_B] | key_fn_i[KEY_FIRE_B];
			game_ctrl_o.up     <= pad_a_i[PAD_UP] | pad_b_i[PAD_UP] | key_fn_i[KEY_UP];
			game_ctrl_o.down   <= pad_a_i[PAD_DOWN] | pad_b_i[PAD_DOWN] | key_fn_i[KEY_DOWN];
			game_ctrl_o.left   <= pad_a_i[PAD_LEFT] | pad_b_i[PAD_LEFT] | key_fn_i[KEY_LEFT];
			game_ctrl_o.right  <= pad_a_i[PAD_RIGHT] | pad_b_i[PAD_RIGHT] | key_fn_i[KEY_RIGHT];
		end
	end

	// Settings toggle once per press of the debounced key
	always_ff @(posedge btn_patrons_s)
	begin
		if (reset_i)
		begin
			clean_q    <= '0;
			settings_o <= '0;
		end
		else
		begin
			clean_q <= buttons_clean_i;
			if (rise[0])
				settings_o.patterns <= ~settings_o.patterns;
			if (rise[1])
				settings_o.scandoubler <= ~settings_o.scandoubler;
		end
	end

	a_patterns_edge: assert property (@(posedge btn_patrons_s) disable iff (reset_i)
		!$stable(settings_o.patterns) |->
			$past(buttons_clean_i[0]) && !$past(buttons_clean_i[0], 2))
		else $error("patterns changed without a key press");

	a_scandb_edge: assert property (@(posedge btn_patrons_s) disable iff (reset_i)
		!$stable(settings_o.scandoubler) |->
			$past(buttons_clean_i[1]) && !$past(buttons_clean_i[1], 2))
		else $error("scandoubler changed without a key press");

endmodule

`default_nettype wire

// ==== design/arcade_input_top.sv ====
// Top level of the player input front end
// Scan sequencer, pad sampler, membrane decoder, debouncer and control merge

`timescale 1ns/100ps
`default_nettype none

module arcade_input_top #(
	parameter int SCAN_DIV      = board_io_pkg::SCAN_DIV_DEFAULT,
	parameter int DEBOUNCE_BITS = board_io_pkg::DEBOUNCE_BITS_DEFAULT
) (
	input  wire                      btn_patrons_s,
	input  wire                      reset_i,
	input  wire board_io_pkg::pad_pins_t joy_pins_i,
	output logic                     joysel_o,
	output board_io_pkg::key_row_t   keyb_row_o,
	input  wire board_io_pkg::key_col_t  keyb_col_i,
	output game_io_pkg::game_ctrl_t  game_ctrl_o,
	output game_io_pkg::settings_t   settings_o
);

	import board_io_pkg::*;
	import game_io_pkg::*;

	row_idx_t  row_idx;
	logic      col_sample;
	pad_pins_t pad_a;
	pad_pins_t pad_b;
	key_fn_t   key_fn;
	logic [1:0] buttons_clean;

	//----------------------------------------------------------------------
	// Scan timing
	//----------------------------------------------------------------------

	scan_sequencer #(.SCAN_DIV(SCAN_DIV)) u_scan_sequencer (
		.btn_patrons_s (btn_patrons_s),
		.reset_i       (reset_i),
		.joysel_o      (joysel_o),
		.row_idx_o     (row_idx),
		.col_sample_o  (col_sample)
	);

	//----------------------------------------------------------------------
	// Input sources
	//----------------------------------------------------------------------

	pad_sampler u_pad_sampler (
		.btn_patrons_s (btn_patrons_s),
		.reset_i       (reset_i),
		.joysel_i      (joysel_o),
		.joy_pins_i    (joy_pins_i),
		.pad_a_o       (pad_a),
		.pad_b_o       (pad_b)
	);

	membrane_decoder u_membrane_decoder (
		.btn_patrons_s (btn_patrons_s),
		.reset_i       (reset_i),
		.row_idx_i     (row_idx),
		.col_sample_i  (col_sample),
		.keyb_col_i    (keyb_col_i),
		.keyb_row_o    (keyb_row_o),
		.key_fn_o      (key_fn)
	);

	// Settings keys only
	debounce_bank #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) u_debounce_bank (
		.btn_patrons_s (btn_patrons_s),
		.reset_i       (reset_i),
		.raw_i         (key_fn[KEY_SCANDB:KEY_PATTERNS]),
		.clean_o       (buttons_clean)
	);

	control_merge u_control_merge (
		.btn_patrons_s   (btn_patrons_s),
		.reset_i         (reset_i),
		.pad_a_i         (pad_a),
		.pad_b_i         (pad_b),
		.key_fn_i        (key_fn),
		.buttons_clean_i (buttons_clean),
		.game_ctrl_o     (game_ctrl_o),
		.settings_o      (settings_o)
	);

endmodule

`default_nettype wire

// ==== test/tb_stimulus_table.svh ====
// Stimulus table for the input front end testbench
// Pad buttons, held membrane keys, expected controls and settings per entry

`ifndef TB_STIMULUS_TABLE_SVH
`define TB_STIMULUS_TABLE_SVH

// One table row with pads and keys active high
typedef struct packed {
	pad_pins_t  pad_a;
	pad_pins_t  pad_b;
	key_fn_t    keys;
	game_ctrl_t exp_ctrl;
	settings_t  exp_set;
} stim_entry_t;

localparam int NUM_ENTRIES = 18;

// Columns:
//   pad_a, pad_b  fires (B A), directions (up down left right)
//   keys          settings (scandb patterns), coin start1 start2, fires (A B), directions
//   exp_ctrl      coin start1 start2, fires (A B), directions
//   exp_set       patterns scandoubler
localparam stim_entry_t TABLE [NUM_ENTRIES] = '{
	'{6'b00_0000, 6'b00_0000, 11'b00_000_000000, 9'b000_000000, 2'b00},
	// Pads alone, then both at once
	'{6'b01_0001, 6'b00_0000, 11'b00_000_000000, 9'b000_100001, 2'b00},
	'{6'b00_0000, 6'b10_1000, 11'b00_000_000000, 9'b000_011000, 2'b00},
	'{6'b01_0010, 6'b10_0110, 11'b00_000_000000, 9'b000_110110, 2'b00},
	// Coin and starts from the membrane
	'{6'b00_0000, 6'b00_0000, 11'b00_100_000000, 9'b100_000000, 2'b00},
	'{6'b00_0000, 6'b00_0000, 11'b00_010_000000, 9'b010_000000, 2'b00},
	'{6'b00_0100, 6'b00_0000, 11'b00_001_001000, 9'b001_001100, 2'b00},
	'{6'b00_0000, 6'b00_0100, 11'b00_000_100001, 9'b000_100101, 2'b00},
	// Patterns press, release, press, release
	'{6'b00_0000, 6'b00_0000, 11'b01_000_000000, 9'b000_000000, 2'b10},
	'{6'b00_0000, 6'b00_0000, 11'b00_000_000000, 9'b000_000000, 2'b10},
	'{6'b00_0000, 6'b00_0000, 11'b01_000_000000, 9'b000_000000, 2'b00},
	'{6'b00_0000, 6'b00_0000, 11'b00_000_000000, 9'b000_000000, 2'b00},
	// Scan doubler key held over three entries
	'{6'b00_0000, 6'b00_0000, 11'b10_000_000000, 9'b000_000000, 2'b01},
	'{6'b00_1000, 6'b00_0000, 11'b10_000_000000, 9'b000_001000, 2'b01},
	'{6'b00_0000, 6'b00_0000, 11'b10_000_000000, 9'b000_000000, 2'b01},
	'{6'b00_0000, 6'b00_0000, 11'b00_000_000000, 9'b000_000000, 2'b01},
	'{6'b00_0000, 6'b00_0000, 11'b01_000_010010, 9'b000_010010, 2'b11},
	'{6'b00_0000, 6'b00_0000, 11'b00_000_000000, 9'b000_000000, 2'b11}
};

`endif

// ==== test/tb_arcade_input.sv ====
// Testbench for the player input front end
// Clock, reset, pad and membrane models, table loop, checks and timeout

`timescale 1ns/100ps
`default_nettype none

module tb_arcade_input;

	import board_io_pkg::*;
	import game_io_pkg::*;

	localparam int SCAN_DIV      = 4;
	localparam int DEBOUNCE_BITS = 3;
	localparam int RESET_CYCLES  = 8;
	// Full keyboard pass, debounce time and output registers
	localparam int HOLD_CYCLES   = 8 * SCAN_DIV + (1 << DEBOUNCE_BITS) + 8;

	`include "tb_stimulus_table.svh"

	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * HOLD_CYCLES + 100;

	logic        btn_patrons_s;
	logic        reset_i;
	pad_pins_t   joy_pins_i;
	logic        joysel_o;
	key_row_t    keyb_row_o;
	key_col_t    keyb_col_i;
	game_ctrl_t  game_ctrl_o;
	settings_t   settings_o;

	stim_entry_t cur;
	int          cycle_count = 0;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        test_bad;

	arcade_input_top #(
		.SCAN_DIV      (SCAN_DIV),
		.DEBOUNCE_BITS (DEBOUNCE_BITS)
	) dut_i (
		.btn_patrons_s (btn_patrons_s),
		.reset_i       (reset_i),
		.joy_pins_i    (joy_pins_i),
		.joysel_o      (joysel_o),
		.keyb_row_o    (keyb_row_o),
		.keyb_col_i    (keyb_col_i),
		.game_ctrl_o   (game_ctrl_o),
		.settings_o    (settings_o)
	);

	initial
	begin
		btn_patrons_s = 1'b0;
		forever
		begin
			#2 btn_patrons_s = ~btn_patrons_s;
		end
	end

	always @(posedge btn_patrons_s)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped, no result after %0d clock cycles", cycle_count);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------

	task automatic check_ctrl(input game_ctrl_t got, input game_ctrl_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s controls %b, expected %b", $time, what, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_settings(input settings_t got, input settings_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s settings %b, expected %b", $time, what, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_row(input key_row_t got, input key_row_t exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s row drive %b, expected %b", $time, what, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic check_select(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAIL time %0t: %s pad select %b, expected %b", $time, what, got, exp);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	// Every function needs a key of its own inside the 8x7 matrix
	task automatic check_key_map();
		for (int i = 0; i < KEY_FN_BITS; i++)
		begin
			if (KEY_MAP[i].col > 3'd6)
			begin
				$display("Key function %0d sits on a column the keyboard lacks", i);
				errors++;
				test_bad = 1'b1;
			end
			for (int j = i + 1; j < KEY_FN_BITS; j++)
			begin
				if (KEY_MAP[i] == KEY_MAP[j])
				begin
					$display("Key functions %0d and %0d share one key", i, j);
					errors++;
					test_bad = 1'b1;
				end
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_bad)
			tests_failed++;
		$display("test %0d %s: %s", tests_run, name, test_bad ? "failed" : "passed");
	endtask

	//----------------------------------------------------------------------
	// Pad and membrane models for one falling edge
	//----------------------------------------------------------------------

	task automatic step_cycle();
		key_col_t  cols;
		pad_pins_t pressed;
		@(negedge btn_patrons_s);
		if ($countones(~keyb_row_o) > 1)
		begin
			$display("Keyboard has more than one row driven low at time %0t", $time);
			errors++;
			test_bad = 1'b1;
		end
		// Connector shows the pad named by the select phase
		pressed    = joysel_o ? cur.pad_b : cur.pad_a;
		joy_pins_i = ~pressed;
		// Held key on the driven row pulls its column low
		cols = '1;
		for (int k = 0; k < KEY_FN_BITS; k++)
		begin
			if (cur.keys[k] && !keyb_row_o[KEY_MAP[k].row])
				cols[KEY_MAP[k].col] = 1'b0;
		end
		keyb_col_i = cols;
	endtask

	//----------------------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------------------

	initial
	begin
		reset_i      = 1'b1;
		joy_pins_i   = '1;
		keyb_col_i   = '1;
		cur          = '0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		test_bad = 1'b0;
		check_key_map();
		finish_test("key map");

		test_bad = 1'b0;
		repeat (RESET_CYCLES) step_cycle();
		check_ctrl(game_ctrl_o, '0, "reset");
		check_settings(settings_o, '0, "reset");
		check_row(keyb_row_o, '1, "reset");
		check_select(joysel_o, 1'b0, "reset");
		reset_i = 1'b0;
		finish_test("reset state");

		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			test_bad = 1'b0;
			cur      = TABLE[i];
			repeat (HOLD_CYCLES) step_cycle();
			check_ctrl(game_ctrl_o, cur.exp_ctrl, $sformatf("entry %0d", i));
			check_settings(settings_o, cur.exp_set, $sformatf("entry %0d", i));
			finish_test($sformatf("entry %0d", i));
		end

		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+test
design/board_io_pkg.sv
design/game_io_pkg.sv
design/scan_sequencer.sv
design/pad_sampler.sv
design/membrane_decoder.sv
design/debounce_bank.sv
design/control_merge.sv
design/arcade_input_top.sv
test/tb_arcade_input.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the input front end testbench with Verilator

verilator --binary --timing --assert -f vlog.f --top-module tb_arcade_input \
	-Mdir obj_dir -o tb_arcade_input > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_arcade_input > sim.log 2>&1
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
